//--- apb_pkg.sv
//######################################################################
// APB port types and register map for the scene bound registers
//######################################################################
`default_nettype none

package apb_pkg;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [4:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// byte offsets
	typedef enum logic [4:0] {
		REG_XMIN = 5'h00,
		REG_XMAX = 5'h04,
		REG_YMIN = 5'h08,
		REG_YMAX = 5'h0c,
		REG_ZMIN = 5'h10,
		REG_ZMAX = 5'h14
	} reg_addr_t;

	// same bus word seen as raw bits or as a fixed-point bound
	typedef union packed {
		ray_pkg::fixed_t fix;
		logic [31:0] raw;
	} reg_word_u;

	typedef struct packed {
		ray_pkg::fixed_t xmin;
		ray_pkg::fixed_t xmax;
		ray_pkg::fixed_t ymin;
		ray_pkg::fixed_t ymax;
		ray_pkg::fixed_t zmin;
		ray_pkg::fixed_t zmax;
	} bounds_t;

endpackage

`default_nettype wire

//--- ray_pkg.sv
//######################################################################
// Ray geometry types for the scene intersection unit
// Q16.16 coordinates, rays, per-axis divider operands and results
//######################################################################
`default_nettype none

package ray_pkg;

	typedef logic signed [31:0] fixed_t;	// signed Q16.16

	typedef struct packed {
		fixed_t x;
		fixed_t y;
		fixed_t z;
	} vec3_t;

	typedef struct packed {
		vec3_t origin;
		vec3_t dir;
		logic is_shadow;
	} ray_t;

	typedef enum logic [1:0] {
		AXIS_X,
		AXIS_Y,
		AXIS_Z
	} axis_t;

	typedef struct packed {
		fixed_t tmin;
		fixed_t tmax;
		logic miss;
	} hit_t;

	// one axis worth of divider operands
	typedef struct packed {
		fixed_t num_lo;
		fixed_t num_hi;
		fixed_t den;
	} slab_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the scene_int testbench with Verilator
set -e

verilator --binary -j 0 -f scene_int.f --top-module tb_scene_int -o sim_scene_int
./obj_dir/sim_scene_int | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- scene_defs.svh
//######################################################################
// Fixed-point format and constants of the scene intersection unit
//######################################################################
`ifndef SCENE_DEFS_SVH
`define SCENE_DEFS_SVH

`define FIX_FRAC 16
`define FIX_ONE 32'sh0001_0000
`define EPSILON 32'sh0000_0042
`define FIX_MAX 32'sh7fff_ffff
`define FIX_MIN 32'sh8000_0000

// quotient bits produced per division
`define DIV_ITERS 33

`endif

//--- scene_int.f
+incdir+.
ray_pkg.sv
apb_pkg.sv
scene_regs.sv
slab_ctrl.sv
slab_div.sv
slab_merge.sv
scene_int.sv
tb_scene_int.sv

//--- scene_int.sv
//######################################################################
// Scene intersection unit
// clips a ray against the scene box, reports tmin, tmax and miss
//######################################################################
`default_nettype none

module scene_int (
	input wire logic clk,
	input wire logic rst,
	input wire apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input wire ray_pkg::ray_t ray_in,
	input wire logic ray_valid,
	output logic ray_ready,
	output ray_pkg::hit_t hit,
	output logic hit_valid
);

	apb_pkg::bounds_t bounds;
	ray_pkg::slab_t slab;
	ray_pkg::fixed_t q_lo;
	ray_pkg::fixed_t q_hi;
	logic div_start;
	logic div_done;
	logic merge_en;
	logic merge_first;
	logic merge_last;
	logic dir_neg;
	logic is_shadow;

	scene_regs regs0 (
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.bounds(bounds)
	);

	slab_ctrl ctrl0 (
		.clk(clk),
		.rst(rst),
		.ray_in(ray_in),
		.ray_valid(ray_valid),
		.bounds(bounds),
		.div_done(div_done),
		.ray_ready(ray_ready),
		.slab(slab),
		.div_start(div_start),
		.merge_en(merge_en),
		.merge_first(merge_first),
		.merge_last(merge_last),
		.dir_neg(dir_neg),
		.is_shadow(is_shadow)
	);

	slab_div div0 (
		.clk(clk),
		.rst(rst),
		.slab(slab),
		.start(div_start),
		.q_lo(q_lo),
		.q_hi(q_hi),
		.done(div_done)
	);

	slab_merge merge0 (
		.clk(clk),
		.rst(rst),
		.q_lo(q_lo),
		.q_hi(q_hi),
		.dir_neg(dir_neg),
		.en(merge_en),
		.first(merge_first),
		.last(merge_last),
		.is_shadow(is_shadow),
		.hit(hit),
		.hit_valid(hit_valid)
	);

endmodule

`default_nettype wire

//--- scene_regs.sv
//######################################################################
// Scene bound register bank
// APB slave holding the six box bounds, with read back
//######################################################################
`default_nettype none

module scene_regs (
	input wire logic clk,
	input wire logic rst,
	input wire apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	output apb_pkg::bounds_t bounds
);

	apb_pkg::reg_word_u regs [6];
	logic [2:0] idx;
	logic mapped;
	logic access;

	assign access = apb_req.psel & apb_req.penable;

	always_comb begin
		mapped = 1'b1;
		case (apb_req.paddr)
			apb_pkg::REG_XMIN: idx = 3'd0;
			apb_pkg::REG_XMAX: idx = 3'd1;
			apb_pkg::REG_YMIN: idx = 3'd2;
			apb_pkg::REG_YMAX: idx = 3'd3;
			apb_pkg::REG_ZMIN: idx = 3'd4;
			apb_pkg::REG_ZMAX: idx = 3'd5;
			default: begin
				idx = 3'd0;
				mapped = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 6; i++)
				regs[i].raw <= '0;
		end else if (access && apb_req.pwrite && mapped) begin
			regs[idx].raw <= apb_req.pwdata;
		end
	end

	// zero-wait slave
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access & ~mapped;
	assign apb_rsp.prdata = (access && !apb_req.pwrite && mapped) ? regs[idx].raw : '0;

	assign bounds.xmin = regs[0].fix;
	assign bounds.xmax = regs[1].fix;
	assign bounds.ymin = regs[2].fix;
	assign bounds.ymax = regs[3].fix;
	assign bounds.zmin = regs[4].fix;
	assign bounds.zmax = regs[5].fix;

endmodule

`default_nettype wire

//--- slab_ctrl.sv
//######################################################################
// Slab sequencer
// takes one ray and walks x, y, z through the divider and merger
//######################################################################
`default_nettype none

module slab_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire ray_pkg::ray_t ray_in,
	input wire logic ray_valid,
	input wire apb_pkg::bounds_t bounds,
	input wire logic div_done,
	output logic ray_ready,
	output ray_pkg::slab_t slab,
	output logic div_start,
	output logic merge_en,
	output logic merge_first,
	output logic merge_last,
	output logic dir_neg,
	output logic is_shadow
);

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		DIVIDE,
		MERGE
	} state_t;

	state_t state;
	ray_pkg::axis_t axis;
	ray_pkg::ray_t ray_q;
	ray_pkg::fixed_t org;
	ray_pkg::fixed_t dir;
	ray_pkg::fixed_t lo;
	ray_pkg::fixed_t hi;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			axis <= ray_pkg::AXIS_X;
		end else begin
			case (state)
				IDLE: if (ray_valid) begin
					state <= SETUP;
					axis <= ray_pkg::AXIS_X;
				end
				SETUP: state <= DIVIDE;
				DIVIDE: if (div_done) state <= MERGE;
				MERGE: begin
					if (axis == ray_pkg::AXIS_Z) begin
						state <= IDLE;
					end else begin
						state <= SETUP;
						axis <= ray_pkg::axis_t'(axis + 2'd1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (ray_ready && ray_valid)
			ray_q <= ray_in;

	// divider takes these operands at div_start
	always_comb begin
		case (axis)
			ray_pkg::AXIS_Y: begin
				org = ray_q.origin.y;
				dir = ray_q.dir.y;
				lo = bounds.ymin;
				hi = bounds.ymax;
			end
			ray_pkg::AXIS_Z: begin
				org = ray_q.origin.z;
				dir = ray_q.dir.z;
				lo = bounds.zmin;
				hi = bounds.zmax;
			end
			default: begin
				org = ray_q.origin.x;
				dir = ray_q.dir.x;
				lo = bounds.xmin;
				hi = bounds.xmax;
			end
		endcase
		slab.num_lo = lo - org;	// wraps
		slab.num_hi = hi - org;
		slab.den = dir;
	end

	assign ray_ready = (state == IDLE);
	assign div_start = (state == SETUP);
	assign merge_en = (state == MERGE);
	assign merge_first = (axis == ray_pkg::AXIS_X);
	assign merge_last = (axis == ray_pkg::AXIS_Z);
	assign dir_neg = dir[31];
	assign is_shadow = ray_q.is_shadow;

endmodule

`default_nettype wire

//--- slab_div.sv
//######################################################################
// Twin restoring Q16.16 divider sharing one denominator
//######################################################################
`default_nettype none
`include "scene_defs.svh"

module slab_div (
	input wire logic clk,
	input wire logic rst,
	input wire ray_pkg::slab_t slab,
	input wire logic start,
	output ray_pkg::fixed_t q_lo,
	output ray_pkg::fixed_t q_hi,
	output logic done
);

	ray_pkg::fixed_t num [2];
	logic [31:0] num_mag [2];
	logic [47:0] full [2];
	logic [31:0] ini_rem [2];
	logic ini_ovf [2];
	logic [33:0] trial [2];
	logic [31:0] nxt_rem [2];
	logic [32:0] nxt_dvd [2];
	logic [31:0] den_in_mag;

	logic [5:0] cnt;
	logic [31:0] den_mag;
	logic [31:0] rem [2];
	logic [32:0] dvd [2];	// dividend bits out, quotient bits in
	logic ovf [2];
	logic neg [2];

	// saturating signed result from a magnitude
	function automatic ray_pkg::fixed_t sat(input logic n, input logic o, input logic [32:0] m);
		if (n)
			return (o || m > 33'h0_8000_0000) ? `FIX_MIN : -ray_pkg::fixed_t'(m[31:0]);
		return (o || m > 33'h0_7fff_ffff) ? `FIX_MAX : ray_pkg::fixed_t'(m[31:0]);
	endfunction

	assign num[0] = slab.num_lo;
	assign num[1] = slab.num_hi;
	assign den_in_mag = slab.den[31] ? 32'(-slab.den) : 32'(slab.den);

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			num_mag[i] = num[i][31] ? 32'(-num[i]) : 32'(num[i]);
			full[i] = 48'(num_mag[i]) << `FIX_FRAC;
			ini_rem[i] = 32'(full[i][47:33]);
			ini_ovf[i] = (ini_rem[i] >= den_in_mag);	// also catches zero den
			trial[i] = {1'b0, rem[i], dvd[i][32]} - {2'b00, den_mag};
			if (trial[i][33]) begin
				nxt_rem[i] = {rem[i][30:0], dvd[i][32]};
				nxt_dvd[i] = {dvd[i][31:0], 1'b0};
			end else begin
				nxt_rem[i] = trial[i][31:0];
				nxt_dvd[i] = {dvd[i][31:0], 1'b1};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= (cnt == 6'd1);
			if (start)
				cnt <= 6'(`DIV_ITERS);
			else if (cnt != '0)
				cnt <= cnt - 6'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			den_mag <= den_in_mag;
		for (int i = 0; i < 2; i++) begin
			if (start) begin
				rem[i] <= ini_rem[i];
				dvd[i] <= full[i][32:0];
				ovf[i] <= ini_ovf[i];
				neg[i] <= num[i][31] ^ slab.den[31];	// zero den keeps num sign
			end else if (cnt != '0) begin
				rem[i] <= nxt_rem[i];
				dvd[i] <= nxt_dvd[i];
			end
		end
	end

	assign q_lo = sat(neg[0], ovf[0], dvd[0]);
	assign q_hi = sat(neg[1], ovf[1], dvd[1]);

endmodule

`default_nettype wire

//--- slab_merge.sv
//######################################################################
// Slab interval merger
// orders each axis pair, narrows the interval, clamps the result
//######################################################################
`default_nettype none
`include "scene_defs.svh"

module slab_merge (
	input wire logic clk,
	input wire logic rst,
	input wire ray_pkg::fixed_t q_lo,
	input wire ray_pkg::fixed_t q_hi,
	input wire logic dir_neg,
	input wire logic en,
	input wire logic first,
	input wire logic last,
	input wire logic is_shadow,
	output ray_pkg::hit_t hit,
	output logic hit_valid
);

	ray_pkg::fixed_t near;
	ray_pkg::fixed_t far;
	ray_pkg::fixed_t nmin;
	ray_pkg::fixed_t nmax;
	logic nmiss;

	ray_pkg::fixed_t tmin_acc;
	ray_pkg::fixed_t tmax_acc;
	logic miss_acc;

	always_comb begin
		near = dir_neg ? q_hi : q_lo;	// negative dir enters at the max plane
		far = dir_neg ? q_lo : q_hi;
		if (first) begin
			nmin = near;
			nmax = far;
			nmiss = 1'b0;
		end else begin
			nmin = (near > tmin_acc) ? near : tmin_acc;
			nmax = (far < tmax_acc) ? far : tmax_acc;
			nmiss = miss_acc;
		end
		nmiss = nmiss | (nmin > nmax);
	end

	always_ff @(posedge clk) begin
		if (en) begin
			tmin_acc <= nmin;
			tmax_acc <= nmax;
			miss_acc <= nmiss;
		end
		if (en && last) begin
			hit.tmin <= (nmin > `EPSILON) ? nmin : `EPSILON;
			hit.tmax <= (nmax > `FIX_ONE && !is_shadow) ? nmax : `FIX_ONE;
			hit.miss <= nmiss;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			hit_valid <= 1'b0;
		else
			hit_valid <= en & last;	// single pulse
	end

endmodule

`default_nettype wire

//--- tb_scene_int.sv
//######################################################################
// Testbench for the scene intersection unit
// directed APB and ray tests against a software slab model
//######################################################################
`default_nettype none
`include "scene_defs.svh"

module tb_scene_int;

	localparam ray_pkg::fixed_t ONE = `FIX_ONE;
	localparam ray_pkg::fixed_t HALF = 32'sh0000_8000;
	localparam ray_pkg::fixed_t QTR = 32'sh0000_4000;
	localparam int N_RAYS = 51;
	localparam int LIMIT = N_RAYS * (3 * 36 + 10) + 200;

	logic clk;
	logic rst;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	ray_pkg::ray_t ray_in;
	logic ray_valid;
	logic ray_ready;
	ray_pkg::hit_t hit;
	logic hit_valid;

	int errors = 0;
	int cycles = 0;
	int seed = 40632;
	apb_pkg::bounds_t box;	// what the DUT should hold

	scene_int dut0 (
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.ray_in(ray_in),
		.ray_valid(ray_valid),
		.ray_ready(ray_ready),
		.hit(hit),
		.hit_valid(hit_valid)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("errors: %0d", errors);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_word(input string name, input ray_pkg::fixed_t exp,
			input ray_pkg::fixed_t act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_hit(input string name, input ray_pkg::hit_t exp,
			input ray_pkg::hit_t act);
		check_word({name, ".tmin"}, exp.tmin, act.tmin);
		check_word({name, ".tmax"}, exp.tmax, act.tmax);
		check_bit({name, ".miss"}, exp.miss, act.miss);
	endtask

	// setup phase, access phase, back to idle
	task automatic apb_access(input logic write, input logic [4:0] addr,
			input logic [31:0] wdata, input logic expect_err, output logic [31:0] rdata);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(posedge clk);
		#2;
		apb_req.penable = 1'b1;
		#1;
		if (!apb_rsp.pready) begin
			$display("APB access to address %h did not complete, pready low", addr);
			errors++;
		end
		if (apb_rsp.pslverr && !expect_err) begin
			$display("unexpected slave error on APB access to address %h", addr);
			errors++;
		end else if (!apb_rsp.pslverr && expect_err) begin
			$display("no slave error on APB access to unmapped address %h", addr);
			errors++;
		end
		rdata = apb_rsp.prdata;
		@(posedge clk);
		#2;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
			input logic expect_err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, expect_err, unused);
	endtask

	task automatic apb_read(input logic [4:0] addr, input logic expect_err,
			output logic [31:0] data);
		apb_access(1'b0, addr, 32'h0, expect_err, data);
	endtask

	task automatic set_box(input apb_pkg::bounds_t b);
		apb_write(apb_pkg::REG_XMIN, b.xmin, 1'b0);
		apb_write(apb_pkg::REG_XMAX, b.xmax, 1'b0);
		apb_write(apb_pkg::REG_YMIN, b.ymin, 1'b0);
		apb_write(apb_pkg::REG_YMAX, b.ymax, 1'b0);
		apb_write(apb_pkg::REG_ZMIN, b.zmin, 1'b0);
		apb_write(apb_pkg::REG_ZMAX, b.zmax, 1'b0);
		box = b;
	endtask

	function automatic apb_pkg::bounds_t make_cube(input ray_pkg::fixed_t lo,
			input ray_pkg::fixed_t hi);
		apb_pkg::bounds_t b;
		b.xmin = lo;
		b.ymin = lo;
		b.zmin = lo;
		b.xmax = hi;
		b.ymax = hi;
		b.zmax = hi;
		return b;
	endfunction

	function automatic ray_pkg::ray_t make_ray(input ray_pkg::fixed_t ox,
			input ray_pkg::fixed_t oy, input ray_pkg::fixed_t oz, input ray_pkg::fixed_t dx,
			input ray_pkg::fixed_t dy, input ray_pkg::fixed_t dz, input logic shadow);
		ray_pkg::ray_t r;
		r.origin.x = ox;
		r.origin.y = oy;
		r.origin.z = oz;
		r.dir.x = dx;
		r.dir.y = dy;
		r.dir.z = dz;
		r.is_shadow = shadow;
		return r;
	endfunction

	// (num << 16) / den truncated toward zero and saturated
	function automatic ray_pkg::fixed_t slab_quot(input ray_pkg::fixed_t num,
			input ray_pkg::fixed_t den);
		longint q;
		if (den == 0)
			return (num < 0) ? `FIX_MIN : `FIX_MAX;
		q = (longint'(num) * 65536) / longint'(den);
		if (q > longint'(`FIX_MAX))
			return `FIX_MAX;
		if (q < longint'(`FIX_MIN))
			return `FIX_MIN;
		return ray_pkg::fixed_t'(q);
	endfunction

	function automatic ray_pkg::hit_t model_hit(input ray_pkg::ray_t r,
			input apb_pkg::bounds_t b);
		ray_pkg::fixed_t org [3];
		ray_pkg::fixed_t dir [3];
		ray_pkg::fixed_t lo [3];
		ray_pkg::fixed_t hi [3];
		ray_pkg::fixed_t n_lo;
		ray_pkg::fixed_t n_hi;
		ray_pkg::fixed_t qa;
		ray_pkg::fixed_t qb;
		ray_pkg::fixed_t near;
		ray_pkg::fixed_t far;
		ray_pkg::fixed_t tmin;
		ray_pkg::fixed_t tmax;
		ray_pkg::hit_t h;
		logic miss;
		org = '{r.origin.x, r.origin.y, r.origin.z};
		dir = '{r.dir.x, r.dir.y, r.dir.z};
		lo = '{b.xmin, b.ymin, b.zmin};
		hi = '{b.xmax, b.ymax, b.zmax};
		tmin = 0;
		tmax = 0;
		miss = 1'b0;
		for (int i = 0; i < 3; i++) begin
			n_lo = lo[i] - org[i];	// 32-bit wrap
			n_hi = hi[i] - org[i];
			qa = slab_quot(n_lo, dir[i]);
			qb = slab_quot(n_hi, dir[i]);
			near = (dir[i] < 0) ? qb : qa;
			far = (dir[i] < 0) ? qa : qb;
			if (i == 0 || near > tmin)
				tmin = near;
			if (i == 0 || far < tmax)
				tmax = far;
			if (tmin > tmax)
				miss = 1'b1;
		end
		h.tmin = (tmin > `EPSILON) ? tmin : `EPSILON;
		h.tmax = (tmax > `FIX_ONE && !r.is_shadow) ? tmax : `FIX_ONE;
		h.miss = miss;
		return h;
	endfunction

	// starts and ends 2 units after an edge
	task automatic send_ray(input ray_pkg::ray_t r, output ray_pkg::hit_t h);
		logic seen;
		while (!ray_ready) begin
			@(posedge clk);
			#2;
		end
		ray_in = r;
		ray_valid = 1'b1;
		@(posedge clk);
		#2;
		ray_valid = 1'b0;
		check_bit("ray_ready", 1'b0, ray_ready);
		seen = 1'b0;
		while (!seen) begin
			@(posedge clk);
			#1;
			seen = hit_valid;
			if (!seen)
				check_bit("ray_ready", 1'b0, ray_ready);	// busy until result
		end
		h = hit;
		#1;
	endtask

	task automatic run_ray(input ray_pkg::ray_t r, output ray_pkg::hit_t h);
		ray_pkg::hit_t exp;
		send_ray(r, h);
		exp = model_hit(r, box);
		check_hit("hit", exp, h);
	endtask

	task automatic test_registers;
		logic [31:0] rd;
		logic [31:0] val [6];
		for (int i = 0; i < 6; i++) begin
			apb_read(5'(4 * i), 1'b0, rd);
			check_word($sformatf("bound %0d after reset", i), 32'h0, rd);
		end
		for (int i = 0; i < 6; i++) begin
			val[i] = 32'h1357_0000 ^ (i * 32'h0011_2233) ^ 32'(i + 1);
			apb_write(5'(4 * i), val[i], 1'b0);
		end
		for (int i = 0; i < 6; i++) begin
			apb_read(5'(4 * i), 1'b0, rd);
			check_word($sformatf("bound %0d", i), val[i], rd);
		end
		apb_write(5'h18, 32'hdead_beef, 1'b1);
		apb_write(5'h02, 32'hcafe_f00d, 1'b1);
		apb_read(5'h1c, 1'b1, rd);
		for (int i = 0; i < 6; i++) begin
			apb_read(5'(4 * i), 1'b0, rd);
			check_word($sformatf("bound %0d after unmapped write", i), val[i], rd);
		end
	endtask

	task automatic test_axis_hits;
		ray_pkg::hit_t h;
		set_box(make_cube(-ONE, ONE));
		run_ray(make_ray(-3 * ONE, HALF, -QTR, ONE, 0, 0, 1'b0), h);
		run_ray(make_ray(3 * ONE, -HALF, QTR, -ONE, 0, 0, 1'b0), h);
		run_ray(make_ray(QTR, -3 * ONE, HALF, 0, 2 * ONE, 0, 1'b0), h);
		run_ray(make_ray(-QTR, 3 * ONE, 0, 0, -HALF, 0, 1'b0), h);
		run_ray(make_ray(0, QTR, -4 * ONE, 0, 0, ONE, 1'b0), h);
		run_ray(make_ray(HALF, 0, 4 * ONE, 0, 0, -2 * ONE, 1'b0), h);
	endtask

	task automatic test_misses;
		ray_pkg::hit_t h;
		run_ray(make_ray(-3 * ONE, ONE + HALF, 0, ONE, QTR, 0, 1'b0), h);
		check_bit("miss beside box", 1'b1, h.miss);
		// zero y direction with the origin above the y slab
		run_ray(make_ray(-3 * ONE, 3 * ONE, 0, ONE, 0, 0, 1'b0), h);
		check_bit("miss zero dir", 1'b1, h.miss);
	endtask

	task automatic test_clamping;
		ray_pkg::hit_t h;
		run_ray(make_ray(0, 0, 0, ONE, ONE, ONE, 1'b0), h);
		check_word("tmin inside box", `EPSILON, h.tmin);
		run_ray(make_ray(-3 * ONE, 0, 0, ONE, 0, 0, 1'b1), h);
		check_word("tmax shadow", `FIX_ONE, h.tmax);
		run_ray(make_ray(-3 * ONE, 0, 0, 8 * ONE, 0, 0, 1'b0), h);
		check_word("tmax below one", `FIX_ONE, h.tmax);
	endtask

	task automatic test_random_rays;
		apb_pkg::bounds_t b;
		ray_pkg::ray_t r;
		ray_pkg::hit_t h;
		logic [31:0] rnd;
		b.xmin = -2 * ONE;
		b.xmax = ONE + HALF;
		b.ymin = -ONE;
		b.ymax = 2 * ONE;
		b.zmin = -HALF;
		b.zmax = 3 * ONE;
		set_box(b);
		for (int k = 0; k < 40; k++) begin
			r.origin.x = $random(seed) % (4 * ONE);
			r.origin.y = $random(seed) % (4 * ONE);
			r.origin.z = $random(seed) % (4 * ONE);
			r.dir.x = $random(seed) % (2 * ONE);
			r.dir.y = $random(seed) % (2 * ONE);
			r.dir.z = $random(seed) % (2 * ONE);
			if (k % 8 == 3)
				r.dir.y = 0;
			rnd = $random(seed);
			r.is_shadow = rnd[0];
			run_ray(r, h);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		apb_req = '0;
		ray_in = '0;
		ray_valid = 1'b0;
		box = '0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		check_bit("ray_ready after reset", 1'b1, ray_ready);
		check_bit("hit_valid after reset", 1'b0, hit_valid);
		test_registers();
		test_axis_hits();
		test_misses();
		test_clamping();
		test_random_rays();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
